// ==== source/fifo_pkg.sv ====
//====================
// fifo_pkg
// shared widths, constants, pipeline structs
// and sequencer states of the mxv subsystem
//====================
package fifo_pkg;

	//====================
	// sizes
	//====================
	// largest matrix dimension
	localparam int MAX_N = 8;
	// element slots in the matrix fifo
	localparam int DEPTH = 64;
	// pointer width, wraps at DEPTH
	localparam int COUNT_N_N = 6;

	//====================
	// scalar types
	//====================
	// signed matrix or vector element
	typedef logic signed [7:0] data_t;
	// dimension N, 1 to 8
	typedef logic [3:0] nibble_t;
	// address or fill count, holds 64
	typedef logic [6:0] M_address_t;
	// 8 products of 16 bits plus 3 growth bits
	typedef logic signed [18:0] acc_t;
	// row or column index
	typedef logic [2:0] row_t;

	// operand pair, sequencer to mac
	typedef struct packed {
		logic  valid;
		data_t a;
		data_t x;
		logic  last;
		row_t  row;
	} elem_t;

	// one finished row sum
	typedef struct packed {
		logic valid;
		acc_t value;
		row_t row;
	} result_t;

	typedef enum logic {
		IDLE,
		BUSY
	} seq_state_t;

endpackage

// ==== source/fsm_fifo.sv ====
//====================
// fsm_fifo
// gates push and pop requests into ram
// write and read enables
//====================
module fsm_fifo (
	input  logic clk,
	input  logic rst_n,
	input  logic push,
	input  logic pop,
	input  logic full,
	input  logic empty,
	output logic wr_en,
	output logic rd_en
);

	// full and empty arrive registered from the pointer block
	// push dropped while full
	assign wr_en = push & ~full;
	// pop ignored while empty
	assign rd_en = pop & ~empty;

	//====================
	// checks
	//====================
	// no write into a full store
	wr_not_full_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		wr_en |-> !full
	);

	// no read from an empty store
	rd_not_empty_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		rd_en |-> !empty
	);

endmodule

// ==== source/pointers_M.sv ====
//====================
// pointers_M
// write/read pointers, fill count and
// full, empty, ready status for size N
//====================
module pointers_M
	import fifo_pkg::*;
#(
	parameter int MAX_DIM = MAX_N
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 push,
	input  logic                 pop,
	input  nibble_t              N,
	output logic [COUNT_N_N-1:0] count_push,
	output logic [COUNT_N_N-1:0] count_pop,
	output logic                 full,
	output logic                 empty,
	output logic                 ready
);

	// elements stored
	M_address_t count_q;
	// clamped dimension
	nibble_t    n_eff;
	// elements in one matrix
	M_address_t n_sq;

	// N above MAX_DIM treated as MAX_DIM, zero as one
	always_comb begin
		if (N > nibble_t'(MAX_DIM)) begin
			n_eff = nibble_t'(MAX_DIM);
		end else if (N == '0) begin
			n_eff = nibble_t'(1);
		end else begin
			n_eff = N;
		end
	end

	assign n_sq = M_address_t'(n_eff) * M_address_t'(n_eff);

	//====================
	// pointers and count
	//====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count_push <= '0;
			count_pop  <= '0;
			count_q    <= '0;
		end else begin
			// natural wrap at DEPTH
			if (push) begin
				count_push <= count_push + 1'b1;
			end
			if (pop) begin
				count_pop <= count_pop + 1'b1;
			end
			// simultaneous push and pop keep the count
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// status from the registered count
	assign full  = (count_q == M_address_t'(DEPTH));
	assign empty = (count_q == '0);
	// whole matrix stored
	assign ready = (count_q >= n_sq);

	// occupancy bounded by the store size
	count_range_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		count_q <= M_address_t'(DEPTH)
	);

endmodule

// ==== source/ram_matrix.sv ====
//====================
// ram_matrix
// element store, one write port and a
// registered read port
//====================
module ram_matrix
	import fifo_pkg::*;
(
	input  logic       clk,
	input  logic       wr_en,
	input  logic       rd_en,
	input  M_address_t count_push,
	input  M_address_t count_pop,
	input  data_t      data_in,
	output data_t      data_out
);

	data_t mem [DEPTH];

	// write at the end of the wr_en cycle
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[count_push[COUNT_N_N-1:0]] <= data_in;
		end
	end

	// popped element shows one cycle after rd_en
	// holds its value between pops
	always_ff @(posedge clk) begin
		if (rd_en) begin
			data_out <= mem[count_pop[COUNT_N_N-1:0]];
		end
	end

endmodule

// ==== source/fifo_matrix.sv ====
//====================
// fifo_matrix
// matrix fifo stage, control, pointers and ram
//====================
module fifo_matrix
	import fifo_pkg::*;
#(
	parameter int MAX_DIM = MAX_N
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    pop,
	input  logic    push,
	input  data_t   data_in,
	input  nibble_t N,
	output logic    full,
	output logic    empty,
	output logic    ready,
	output data_t   data_out
);

	// gated enables
	logic wr_en_w;
	logic rd_en_w;
	// pointers from pointers_M
	logic [COUNT_N_N-1:0] wr_ptr_w;
	logic [COUNT_N_N-1:0] rd_ptr_w;

	//====================
	// control
	//====================
	fsm_fifo fsm_fifo_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.push  (push),
		.pop   (pop),
		.full  (full),
		.empty (empty),
		.wr_en (wr_en_w),
		.rd_en (rd_en_w)
	);

	// store
	ram_matrix ram_matrix_inst (
		.clk        (clk),
		.wr_en      (wr_en_w),
		.rd_en      (rd_en_w),
		.count_push (M_address_t'(wr_ptr_w)),
		.count_pop  (M_address_t'(rd_ptr_w)),
		.data_in    (data_in),
		.data_out   (data_out)
	);

	// pointers advance on the gated enables only
	pointers_M #(
		.MAX_DIM (MAX_DIM)
	) pointers_M_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (wr_en_w),
		.pop        (rd_en_w),
		.N          (N),
		.count_push (wr_ptr_w),
		.count_pop  (rd_ptr_w),
		.full       (full),
		.empty      (empty),
		.ready      (ready)
	);

endmodule

// ==== source/row_sequencer.sv ====
//====================
// row_sequencer
// vector register, start control, pops
// and row/column tracking
//====================
module row_sequencer
	import fifo_pkg::*;
#(
	parameter int MAX_DIM = MAX_N
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    start,
	input  logic    ready,
	input  logic    vec_wr,
	input  row_t    vec_idx,
	input  data_t   vec_data,
	input  nibble_t N,
	input  data_t   fifo_data,
	output logic    pop,
	output logic    busy,
	output elem_t   elem
);

	seq_state_t state_q;
	data_t      vec_q [MAX_DIM];
	// position of the element popped this cycle
	row_t       col_q;
	row_t       row_q;
	// N-1 latched at start
	row_t       last_idx_q;
	// all pops issued, waiting for the final element
	logic       drain_q;
	nibble_t    n_eff;
	logic       start_ok;
	logic       col_end;
	logic       row_end;
	// one cycle behind, lined up with fifo_data
	logic       valid_d;
	logic       last_d;
	row_t       col_d;
	row_t       row_d;

	// clamp N into 1..MAX_DIM
	always_comb begin
		if (N > nibble_t'(MAX_DIM)) begin
			n_eff = nibble_t'(MAX_DIM);
		end else if (N == '0) begin
			n_eff = nibble_t'(1);
		end else begin
			n_eff = N;
		end
	end

	assign busy     = (state_q == BUSY);
	assign pop      = busy && !drain_q;
	// new start ignored while busy or before a full matrix
	assign start_ok = (state_q == IDLE) && start && ready;
	assign col_end  = (col_q == last_idx_q);
	assign row_end  = (row_q == last_idx_q);

	// vector writes only while idle
	always_ff @(posedge clk) begin
		if (state_q == IDLE && vec_wr && int'(vec_idx) < MAX_DIM) begin
			vec_q[vec_idx] <= vec_data;
		end
	end

	//====================
	// state and counters
	//====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q    <= IDLE;
			col_q      <= '0;
			row_q      <= '0;
			last_idx_q <= '0;
			drain_q    <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (start_ok) begin
						state_q    <= BUSY;
						col_q      <= '0;
						row_q      <= '0;
						last_idx_q <= row_t'(n_eff - 1'b1);
						drain_q    <= 1'b0;
					end
				end
				BUSY: begin
					if (drain_q) begin
						// final element on elem this cycle
						state_q <= IDLE;
						drain_q <= 1'b0;
					end else if (col_end) begin
						col_q <= '0;
						row_q <= row_q + 1'b1;
						drain_q <= row_end;
					end else begin
						col_q <= col_q + 1'b1;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// element strobe follows pop by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_d <= 1'b0;
		end else begin
			valid_d <= pop;
		end
	end

	// tags of the popped element
	always_ff @(posedge clk) begin
		if (pop) begin
			col_d  <= col_q;
			row_d  <= row_q;
			last_d <= col_end;
		end
	end

	always_comb begin
		elem.valid = valid_d;
		elem.a     = fifo_data;
		elem.x     = vec_q[col_d];
		elem.last  = last_d;
		elem.row   = row_d;
	end

	// pops only inside a run
	pop_in_run_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		pop |-> busy
	);

endmodule

// ==== source/mac_stage.sv ====
//====================
// mac_stage
// signed multiply-accumulate per row,
// one result strobe per row
//====================
module mac_stage
	import fifo_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  elem_t   elem,
	output result_t result
);

	acc_t               acc_q;
	logic signed [15:0] prod;
	// running sum including this element
	acc_t               sum;
	logic               valid_q;
	acc_t               value_q;
	row_t               row_q;

	assign prod = $signed(elem.a) * $signed(elem.x);
	// sign extend into the accumulator width
	assign sum  = acc_q + acc_t'(prod);

	//====================
	// accumulator
	//====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_q   <= '0;
			valid_q <= 1'b0;
		end else begin
			// single cycle strobe
			valid_q <= elem.valid && elem.last;
			if (elem.valid) begin
				// restart at zero so the next row follows without a gap
				if (elem.last) begin
					acc_q <= '0;
				end else begin
					acc_q <= sum;
				end
			end
		end
	end

	// completed row sum and its index
	always_ff @(posedge clk) begin
		if (elem.valid && elem.last) begin
			value_q <= sum;
			row_q   <= elem.row;
		end
	end

	always_comb begin
		result.valid = valid_q;
		result.value = value_q;
		result.row   = row_q;
	end

endmodule

// ==== source/mxv_top.sv ====
//====================
// mxv_top
// matrix by vector multiplier, fifo,
// sequencer and mac chained in a pipeline
//====================
module mxv_top
	import fifo_pkg::*;
#(
	parameter int MAX_DIM = MAX_N
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    push,
	input  data_t   data_in,
	input  nibble_t N,
	input  logic    vec_wr,
	input  row_t    vec_idx,
	input  data_t   vec_data,
	input  logic    start,
	output logic    full,
	output logic    empty,
	output logic    ready,
	output logic    busy,
	output result_t result
);

	logic  pop_w;
	data_t fifo_data_w;
	elem_t elem_w;

	//====================
	// stage 1, matrix fifo
	//====================
	fifo_matrix #(
		.MAX_DIM (MAX_DIM)
	) fifo_matrix_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.pop      (pop_w),
		.push     (push),
		.data_in  (data_in),
		.N        (N),
		.full     (full),
		.empty    (empty),
		.ready    (ready),
		.data_out (fifo_data_w)
	);

	// stage 2, pops and pairs elements with the vector
	row_sequencer #(
		.MAX_DIM (MAX_DIM)
	) row_sequencer_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.ready     (ready),
		.vec_wr    (vec_wr),
		.vec_idx   (vec_idx),
		.vec_data  (vec_data),
		.N         (N),
		.fifo_data (fifo_data_w),
		.pop       (pop_w),
		.busy      (busy),
		.elem      (elem_w)
	);

	// stage 3, row sums
	mac_stage mac_stage_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.elem   (elem_w),
		.result (result)
	);

endmodule

// ==== sim/tb_mxv.sv ====
//====================
// tb_mxv
// trace driven testbench for the matrix by
// vector multiplier
//====================
module tb_mxv
	import fifo_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TRACE_WORDS       = 256;
	// watchdog budget per record and fixed margin
	localparam int CYCLES_PER_RECORD = 200;
	localparam int MARGIN_CYCLES     = 500;

	logic    clk;
	logic    rst_n;
	logic    push;
	data_t   data_in;
	nibble_t N;
	logic    vec_wr;
	row_t    vec_idx;
	data_t   vec_data;
	logic    start;
	logic    full;
	logic    empty;
	logic    ready;
	logic    busy;
	result_t result;

	// flat trace image, see the trace file for the layout
	logic [19:0] trace_mem [0:TRACE_WORDS-1];
	integer      seed;
	int          num_records;
	int          limit_cycles;
	int          trace_ptr;

	mxv_top #(
		.MAX_DIM (8)
	) mxv_top_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.push     (push),
		.data_in  (data_in),
		.N        (N),
		.vec_wr   (vec_wr),
		.vec_idx  (vec_idx),
		.vec_data (vec_data),
		.start    (start),
		.full     (full),
		.empty    (empty),
		.ready    (ready),
		.busy     (busy),
		.result   (result)
	);

	// 40 ns period
	always #20 clk = ~clk;

	//====================
	// helpers
	//====================
	task automatic check_value(input string what, input logic signed [31:0] got,
		input logic signed [31:0] expected);
		if (got !== expected) begin
			$display("[FAIL] %0t ns: %s, got %0d, expected %0d", $time, what, got, expected);
			$display("Simulation finished: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	task automatic trace_error(input string reason);
		$display("The trace file could not be used: %s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "bad trace");
	endtask

	// inputs change 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic push_element(input data_t value);
		push    = 1'b1;
		data_in = value;
		next_cycle();
		push = 1'b0;
	endtask

	// walk the record headers up to the N = 0 terminator
	task automatic scan_trace(output int records);
		int ptr;
		int n;
		ptr     = 0;
		records = 0;
		while (1) begin
			if (ptr >= TRACE_WORDS || $isunknown(trace_mem[ptr])) begin
				trace_error("a record header is missing or unreadable");
			end
			n = int'(trace_mem[ptr]);
			if (n == 0) begin
				break;
			end
			if (n > 8) begin
				trace_error("a record has a dimension above 8");
			end
			ptr += 2 + n * n + 2 * n;
			records++;
		end
	endtask

	task automatic check_reset_state();
		check_value("empty after reset", empty, 1);
		check_value("full after reset", full, 0);
		check_value("ready after reset", ready, 0);
		check_value("busy after reset", busy, 0);
		check_value("result strobe after reset", result.valid, 0);
	endtask

	//====================
	// one trace record
	//====================
	task automatic run_record(inout int ptr);
		int   n;
		int   extra;
		int   mat_base;
		int   vec_base;
		int   exp_base;
		int   idle;
		int   waited;
		acc_t expected;
		n        = int'(trace_mem[ptr]);
		extra    = int'(trace_mem[ptr + 1]);
		mat_base = ptr + 2;
		vec_base = mat_base + n * n;
		exp_base = vec_base + n;
		ptr      = exp_base + n;
		N = nibble_t'(n);
		next_cycle();

		// start with an incomplete matrix must do nothing
		check_value("ready before loading", ready, 0);
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		repeat (3) begin
			check_value("busy after early start", busy, 0);
			check_value("result after early start", result.valid, 0);
			next_cycle();
		end

		// row-major pushes with random gaps
		for (int k = 1; k <= n * n; k++) begin
			idle = $unsigned($random(seed)) % 3;
			repeat (idle) next_cycle();
			push_element(data_t'(trace_mem[mat_base + k - 1][7:0]));
			check_value("ready while loading", ready, k == n * n);
			check_value("full while loading", full, k == DEPTH);
		end

		// pushes into a full fifo get dropped
		for (int e = 0; e < extra; e++) begin
			push_element(data_t'($random(seed)));
			check_value("full after dropped push", full, 1);
			check_value("ready after dropped push", ready, 1);
		end

		for (int j = 0; j < n; j++) begin
			vec_wr   = 1'b1;
			vec_idx  = row_t'(j);
			vec_data = data_t'(trace_mem[vec_base + j][7:0]);
			next_cycle();
		end
		vec_wr = 1'b0;

		start = 1'b1;
		next_cycle();
		start = 1'b0;
		check_value("busy after accepted start", busy, 1);
		waited = 1;

		// first row after N+2 cycles, then one every N
		for (int r = 0; r < n; r++) begin
			do begin
				next_cycle();
				waited++;
			end while (result.valid !== 1'b1);
			expected = acc_t'(trace_mem[exp_base + r]);
			check_value((r == 0) ? "first result latency" : "result spacing",
				waited, (r == 0) ? n + 2 : n);
			check_value("result row", result.row, r);
			check_value("result value", $signed(result.value), expected);
			waited = 0;
		end

		// all N*N elements consumed
		next_cycle();
		check_value("result strobe length", result.valid, 0);
		check_value("busy after run", busy, 0);
		check_value("empty after run", empty, 1);
		check_value("ready after run", ready, 0);
	endtask

	//====================
	// main sequence
	//====================
	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		push     = 1'b0;
		data_in  = '0;
		N        = nibble_t'(1);
		vec_wr   = 1'b0;
		vec_idx  = '0;
		vec_data = '0;
		start    = 1'b0;
		seed     = 42676;
		$readmemh("sim/mxv_trace.txt", trace_mem);
		scan_trace(num_records);
		limit_cycles = CYCLES_PER_RECORD * num_records + MARGIN_CYCLES;
		// reset held for 5 cycles
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		next_cycle();
		check_reset_state();
		trace_ptr = 0;
		while (int'(trace_mem[trace_ptr]) != 0) begin
			run_record(trace_ptr);
		end
		$display("Simulation finished: PASS");
		$finish;
	end

	// watchdog, armed once the trace length is known
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== sim/mxv_trace.txt ====
// record: N and extra pushes while full, N matrix rows, vector, expected row sums
// elements are 8 bit two's complement, sums are 20 bit sign extended, N = 0 ends

// N = 1, both operands at -128
1 0
80
80
04000

// N = 3, mixed signs and both extremes
3 0
01 02 03
ff fe fd
7f 80 00
02 ff 05
0000f ffff1 0017e

// N = 8, full fifo with 3 dropped pushes
// extreme rows stress the accumulator width
8 3
80 80 80 80 80 80 80 80
7f 7f 7f 7f 80 80 80 80
80 80 80 80 7f 7f 7f 7f
00 00 00 00 00 00 00 00
01 02 03 04 05 06 07 08
ff ff ff ff ff ff ff ff
01 00 00 00 00 00 00 00
00 00 00 00 00 00 00 01
80 80 80 80 7f 7f 7f 7f
00200 e0400 1fc04 00000 007e6 00004 fff80 0007f

// N = 2, small signed values
2 0
05 fa
07 08
fd 04
fffd9 0000b

// N = 1, 127 times -128
1 0
7f
80
fc080

// end of trace
0 0

// ==== project.f ====
source/fifo_pkg.sv
source/fsm_fifo.sv
source/pointers_M.sv
source/ram_matrix.sv
source/fifo_matrix.sv
source/row_sequencer.sv
source/mac_stage.sv
source/mxv_top.sv
sim/tb_mxv.sv
